//--- hdl/calc_cfg.svh
// Calculator width, completion depth and multiplier stage macros
`ifndef CALC_CFG_SVH
`define CALC_CFG_SVH

// Operand and result width
`define CALC_DATA_W 32

// Register file index width
`define CALC_REG_ADDR_W 5

// Completion stages between reservation slot and writeback
`define CALC_COMP_DEPTH 4

// Multiplier registers
// The product lands in the completion stage with this index
`define CALC_MUL_STAGES 2

`endif

//--- hdl/calc_pkg.sv
// Calculator data types, operation enum and packet structs
`include "calc_cfg.svh"

package calc_pkg;

  typedef logic [`CALC_DATA_W-1:0] calc_data_t;
  typedef logic [`CALC_REG_ADDR_W-1:0] calc_reg_addr_t;

  // Shift amount, taken from the low bits of an operand
  typedef logic [$clog2(`CALC_DATA_W)-1:0] calc_shift_w;

  typedef enum logic [2:0]
  {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLL = 3'd5,
    SRL = 3'd6,
    MUL = 3'd7
  } calc_op_e;

  typedef struct packed
  {
    logic           v;
    calc_op_e       op;
    calc_reg_addr_t rs1_addr;
    calc_reg_addr_t rs2_addr;
    calc_reg_addr_t rd_addr;
    calc_data_t     rs1_data;
    calc_data_t     rs2_data;
  } calc_dispatch_s;

  typedef struct packed
  {
    logic       v;
    calc_data_t data;
  } calc_result_s;

  typedef struct packed
  {
    logic           w_v;
    logic           poison;
    calc_reg_addr_t rd_addr;
    calc_data_t     rd_data;
  } calc_wb_s;

  typedef struct packed
  {
    logic           v;
    calc_reg_addr_t rd_addr;
    calc_data_t     data;
  } calc_fwd_s;

  // Index 0 is the youngest tap
  typedef calc_fwd_s [`CALC_COMP_DEPTH-1:0] calc_fwd_bus_t;

endpackage

//--- hdl/calc_issue.sv
// Issue stage with source operand bypass and the reservation slot register
`timescale 1ns/1ps
`include "calc_cfg.svh"

module calc_issue
(
  input  logic                     clk_i
  , input  logic                   rst_n_i
  , input  calc_pkg::calc_dispatch_s dispatch_pkt_i
  , input  calc_pkg::calc_fwd_bus_t  fwd_i
  , output calc_pkg::calc_dispatch_s reservation_o
);

  calc_pkg::calc_dispatch_s rsv_n;
  calc_pkg::calc_dispatch_s rsv_r;
  logic                     rsv_v_r;

  function automatic calc_pkg::calc_data_t bypass_src
  (
    input calc_pkg::calc_reg_addr_t addr
    , input calc_pkg::calc_data_t   rf_data
    , input calc_pkg::calc_fwd_bus_t fwd
  );
    calc_pkg::calc_data_t data;
    data = rf_data;
    // Oldest tap first so the youngest match is the one kept
    for (int i = `CALC_COMP_DEPTH-1; i >= 0; i--)
    begin
      if (fwd[i].v && (fwd[i].rd_addr == addr))
        data = fwd[i].data;
    end
    // x0 is hardwired
    if (addr == '0)
      data = '0;
    return data;
  endfunction

  always_comb
  begin
    rsv_n          = dispatch_pkt_i;
    rsv_n.rs1_data = bypass_src(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1_data, fwd_i);
    rsv_n.rs2_data = bypass_src(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2_data, fwd_i);
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rsv_v_r <= 1'b0;
    else
      rsv_v_r <= rsv_n.v;
  end

  always_ff @(posedge clk_i)
  begin
    rsv_r <= rsv_n;
  end

  always_comb
  begin
    reservation_o   = rsv_r;
    reservation_o.v = rsv_v_r;
  end

endmodule

//--- hdl/calc_pipe_int.sv
// Single-cycle integer ALU fed from the reservation slot
`timescale 1ns/1ps

module calc_pipe_int
(
  input  calc_pkg::calc_dispatch_s reservation_i
  , output calc_pkg::calc_result_s int_res_o
);

  calc_pkg::calc_data_t  op_a;
  calc_pkg::calc_data_t  op_b;
  calc_pkg::calc_shift_w shamt;
  calc_pkg::calc_data_t  result;

  assign op_a  = reservation_i.rs1_data;
  assign op_b  = reservation_i.rs2_data;
  assign shamt = op_b[$bits(calc_pkg::calc_shift_w)-1:0];

  always_comb
  begin
    case (reservation_i.op)
      calc_pkg::ADD:
        result = op_a + op_b;
      calc_pkg::SUB:
        result = op_a - op_b;
      calc_pkg::AND:
        result = op_a & op_b;
      calc_pkg::OR:
        result = op_a | op_b;
      calc_pkg::XOR:
        result = op_a ^ op_b;
      calc_pkg::SLL:
        result = op_a << shamt;
      calc_pkg::SRL:
        result = op_a >> shamt;
      // MUL goes to the multiplier pipe
      default:
        result = '0;
    endcase
  end

  always_comb
  begin
    int_res_o.v    = reservation_i.v && (reservation_i.op != calc_pkg::MUL);
    int_res_o.data = result;
  end

endmodule

//--- hdl/calc_pipe_mul.sv
// Pipelined multiplier returning the low product word
`timescale 1ns/1ps
`include "calc_cfg.svh"

module calc_pipe_mul
(
  input  logic                     clk_i
  , input  logic                   rst_n_i
  , input  calc_pkg::calc_dispatch_s reservation_i
  , output calc_pkg::calc_result_s   mul_res_o
);

  logic                 mul_v_n;
  calc_pkg::calc_data_t product;

  logic [`CALC_MUL_STAGES-1:0] mul_v_r;
  calc_pkg::calc_data_t        mul_data_r [`CALC_MUL_STAGES];

  assign mul_v_n = reservation_i.v && (reservation_i.op == calc_pkg::MUL);

  // Only the low word is kept
  assign product = reservation_i.rs1_data * reservation_i.rs2_data;

  // Valid bits walk alongside the data
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      mul_v_r <= '0;
    else
    begin
      mul_v_r[0] <= mul_v_n;
      for (int i = 1; i < `CALC_MUL_STAGES; i++)
        mul_v_r[i] <= mul_v_r[i-1];
    end
  end

  always_ff @(posedge clk_i)
  begin
    mul_data_r[0] <= product;
    for (int i = 1; i < `CALC_MUL_STAGES; i++)
      mul_data_r[i] <= mul_data_r[i-1];
  end

  always_comb
  begin
    mul_res_o.v    = mul_v_r[`CALC_MUL_STAGES-1];
    mul_res_o.data = mul_data_r[`CALC_MUL_STAGES-1];
  end

endmodule

//--- hdl/calc_completion.sv
// Completion shift pipeline with result merge, flush poison, writeback and forwarding taps
`timescale 1ns/1ps
`include "calc_cfg.svh"

module calc_completion
(
  input  logic                     clk_i
  , input  logic                   rst_n_i
  , input  logic                   flush_i
  , input  calc_pkg::calc_dispatch_s reservation_i
  , input  calc_pkg::calc_result_s   int_res_i
  , input  calc_pkg::calc_result_s   mul_res_i
  , output calc_pkg::calc_fwd_bus_t  fwd_o
  , output calc_pkg::calc_wb_s       wb_pkt_o
);

  calc_pkg::calc_wb_s [`CALC_COMP_DEPTH-1:0] stage_n;
  calc_pkg::calc_wb_s [`CALC_COMP_DEPTH-1:0] stage_r;
  calc_pkg::calc_wb_s [`CALC_COMP_DEPTH-1:0] stage_q;

  logic [`CALC_COMP_DEPTH-1:0] w_v_r;
  logic [`CALC_COMP_DEPTH-1:0] poison_r;

  // Registered stages with their control bits
  always_comb
  begin
    for (int i = 0; i < `CALC_COMP_DEPTH; i++)
    begin
      stage_q[i]        = stage_r[i];
      stage_q[i].w_v    = w_v_r[i];
      stage_q[i].poison = poison_r[i];
    end
  end

  always_comb
  begin
    stage_n[0].w_v     = reservation_i.v && (reservation_i.rd_addr != '0);
    stage_n[0].poison  = 1'b0;
    stage_n[0].rd_addr = reservation_i.rd_addr;
    stage_n[0].rd_data = '0;
    for (int i = 1; i < `CALC_COMP_DEPTH; i++)
      stage_n[i] = stage_q[i-1];

    // Static latencies, so at most one pipe lands in a stage per cycle
    if (int_res_i.v)
      stage_n[0].rd_data |= int_res_i.data;
    if (mul_res_i.v)
      stage_n[`CALC_MUL_STAGES].rd_data |= mul_res_i.data;

    // Flush kills the two youngest instructions
    stage_n[0].poison |= flush_i;
    stage_n[1].poison |= flush_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      w_v_r    <= '0;
      poison_r <= '0;
    end
    else
    begin
      for (int i = 0; i < `CALC_COMP_DEPTH; i++)
      begin
        w_v_r[i]    <= stage_n[i].w_v;
        poison_r[i] <= stage_n[i].poison;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    stage_r <= stage_n;
  end

  // Taps see next-state values so a result is usable the cycle it lands
  always_comb
  begin
    for (int i = 0; i < `CALC_COMP_DEPTH; i++)
    begin
      fwd_o[i].v       = stage_n[i].w_v && !stage_n[i].poison;
      fwd_o[i].rd_addr = stage_n[i].rd_addr;
      fwd_o[i].data    = stage_n[i].rd_data;
    end
  end

  always_comb
  begin
    wb_pkt_o     = stage_q[`CALC_COMP_DEPTH-1];
    wb_pkt_o.w_v = stage_q[`CALC_COMP_DEPTH-1].w_v && !stage_q[`CALC_COMP_DEPTH-1].poison;
  end

endmodule

//--- hdl/calc_top.sv
// Calculator top level joining issue, integer and multiply pipes and completion
`timescale 1ns/1ps

module calc_top
(
  input  logic                     clk_i
  , input  logic                   rst_n_i
  , input  calc_pkg::calc_dispatch_s dispatch_pkt_i
  , input  logic                   flush_i
  , output calc_pkg::calc_wb_s       wb_pkt_o
);

  calc_pkg::calc_dispatch_s reservation;
  calc_pkg::calc_result_s   int_res;
  calc_pkg::calc_result_s   mul_res;
  calc_pkg::calc_fwd_bus_t  fwd;

  calc_issue i_issue
  (
    .clk_i           (clk_i)
    , .rst_n_i       (rst_n_i)
    , .dispatch_pkt_i(dispatch_pkt_i)
    , .fwd_i         (fwd)
    , .reservation_o (reservation)
  );

  // One cycle latency
  calc_pipe_int i_pipe_int
  (
    .reservation_i(reservation)
    , .int_res_o  (int_res)
  );

  calc_pipe_mul i_pipe_mul
  (
    .clk_i          (clk_i)
    , .rst_n_i      (rst_n_i)
    , .reservation_i(reservation)
    , .mul_res_o    (mul_res)
  );

  calc_completion i_completion
  (
    .clk_i          (clk_i)
    , .rst_n_i      (rst_n_i)
    , .flush_i      (flush_i)
    , .reservation_i(reservation)
    , .int_res_i    (int_res)
    , .mul_res_i    (mul_res)
    , .fwd_o        (fwd)
    , .wb_pkt_o     (wb_pkt_o)
  );

endmodule

//--- bench/calc_tb.sv
// Calculator testbench with clock, reset, program builder, reference model, assertions and watchdog
`timescale 1ns/1ps
`include "calc_cfg.svh"

module calc_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_RAND     = 200;

  logic                     clk;
  logic                     rst_n;
  logic                     flush;
  calc_pkg::calc_dispatch_s dispatch_pkt;
  calc_pkg::calc_wb_s       wb_pkt;

  int seed        = 67;
  int cyc         = 0;
  int wb_seen     = 0;
  int wb_expected = 0;
  bit prog_built  = 1'b0;

  // One slot per cycle with the flush bit sampled at the same edge as the slot
  calc_pkg::calc_dispatch_s prog_q[$];
  bit                       flush_q[$];
  calc_pkg::calc_wb_s       slot_wb[$];

  // Expected last-stage entries and the cycle count each one is due in
  int                 due_q[$];
  calc_pkg::calc_wb_s wb_q[$];
  calc_pkg::calc_wb_s exp_wb = '0;

  calc_top i_dut
  (
    .clk_i           (clk)
    , .rst_n_i       (rst_n)
    , .dispatch_pkt_i(dispatch_pkt)
    , .flush_i       (flush)
    , .wb_pkt_o      (wb_pkt)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(string name, calc_pkg::calc_data_t expected,
                                 calc_pkg::calc_data_t actual);
    $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, expected, actual);
    stop_with_failure("Writeback does not match the reference model");
  endtask

  function automatic calc_pkg::calc_data_t alu_model
  (
    input calc_pkg::calc_op_e     op
    , input calc_pkg::calc_data_t a
    , input calc_pkg::calc_data_t b
  );
    case (op)
      calc_pkg::ADD: return a + b;
      calc_pkg::SUB: return a - b;
      calc_pkg::AND: return a & b;
      calc_pkg::OR:  return a | b;
      calc_pkg::XOR: return a ^ b;
      calc_pkg::SLL: return a << b[4:0];
      calc_pkg::SRL: return a >> b[4:0];
      default:       return a * b;
    endcase
  endfunction

  // A valid producer of r still inside the forwarding window
  function automatic bit in_flight(int k, calc_pkg::calc_reg_addr_t r);
    bit hit;
    hit = 1'b0;
    for (int j = (k > `CALC_COMP_DEPTH) ? k - `CALC_COMP_DEPTH : 0; j < k; j++)
    begin
      if (slot_wb[j].w_v && slot_wb[j].rd_addr == r)
        hit = 1'b1;
    end
    return hit;
  endfunction

  // MUL result not yet in the taps
  function automatic bit mul_hazard(int r);
    bit hit;
    hit = 1'b0;
    for (int j = (prog_q.size() > 2) ? prog_q.size() - 2 : 0; j < prog_q.size(); j++)
    begin
      if (prog_q[j].v && prog_q[j].op == calc_pkg::MUL && r != 0
          && prog_q[j].rd_addr == calc_pkg::calc_reg_addr_t'(r))
        hit = 1'b1;
    end
    return hit;
  endfunction

  task automatic add_slot(bit v, calc_pkg::calc_op_e op, int rd, int rs1, int rs2, bit fl);
    calc_pkg::calc_dispatch_s pkt;
    pkt          = '0;
    pkt.v        = v;
    pkt.op       = op;
    pkt.rd_addr  = calc_pkg::calc_reg_addr_t'(rd);
    pkt.rs1_addr = calc_pkg::calc_reg_addr_t'(rs1);
    pkt.rs2_addr = calc_pkg::calc_reg_addr_t'(rs2);
    prog_q.push_back(pkt);
    flush_q.push_back(fl);
  endtask

  task automatic build_program();
    int rnd;
    int rs1;
    int rs2;
    for (int i = 0; i < 4; i++)
      add_slot(1'b0, calc_pkg::ADD, 0, 0, 0, 1'b0);
    // Each ALU op, then rd of zero and a source of zero
    add_slot(1'b1, calc_pkg::ADD, 16, 8, 9, 1'b0);
    add_slot(1'b1, calc_pkg::SUB, 17, 9, 10, 1'b0);
    add_slot(1'b1, calc_pkg::AND, 18, 10, 11, 1'b0);
    add_slot(1'b1, calc_pkg::OR, 19, 11, 12, 1'b0);
    add_slot(1'b1, calc_pkg::XOR, 20, 12, 13, 1'b0);
    add_slot(1'b1, calc_pkg::SLL, 21, 13, 14, 1'b0);
    add_slot(1'b1, calc_pkg::SRL, 22, 14, 15, 1'b0);
    add_slot(1'b1, calc_pkg::ADD, 0, 8, 9, 1'b0);
    add_slot(1'b1, calc_pkg::OR, 23, 0, 9, 1'b0);
    for (int i = 0; i < 6; i++)
      add_slot(1'b1, calc_pkg::MUL, 24 + i, 8 + i, 16 + i, 1'b0);
    // Dependent chains at distance 1 to 4 and MUL consumers at distance 3
    add_slot(1'b1, calc_pkg::ADD, 1, 2, 3, 1'b0);
    add_slot(1'b1, calc_pkg::SUB, 2, 1, 3, 1'b0);
    add_slot(1'b1, calc_pkg::XOR, 3, 1, 2, 1'b0);
    add_slot(1'b1, calc_pkg::ADD, 4, 1, 3, 1'b0);
    add_slot(1'b1, calc_pkg::OR, 5, 1, 4, 1'b0);
    add_slot(1'b1, calc_pkg::MUL, 6, 5, 2, 1'b0);
    add_slot(1'b0, calc_pkg::ADD, 0, 0, 0, 1'b0);
    add_slot(1'b0, calc_pkg::ADD, 0, 0, 0, 1'b0);
    add_slot(1'b1, calc_pkg::ADD, 7, 6, 5, 1'b0);
    add_slot(1'b1, calc_pkg::MUL, 8, 6, 7, 1'b0);
    add_slot(1'b1, calc_pkg::SLL, 9, 1, 2, 1'b0);
    add_slot(1'b1, calc_pkg::SRL, 10, 3, 4, 1'b0);
    add_slot(1'b1, calc_pkg::SUB, 11, 8, 9, 1'b0);
    // Flush kills the two slots before it while older and younger ones survive
    add_slot(1'b1, calc_pkg::ADD, 12, 1, 2, 1'b0);
    add_slot(1'b1, calc_pkg::ADD, 13, 1, 2, 1'b0);
    add_slot(1'b1, calc_pkg::ADD, 12, 3, 4, 1'b0);
    add_slot(1'b1, calc_pkg::XOR, 14, 12, 13, 1'b1);
    add_slot(1'b1, calc_pkg::ADD, 15, 12, 13, 1'b0);
    // Random mix on a small register set for dense hazards
    for (int i = 0; i < NUM_RAND; i++)
    begin
      rnd = $random(seed);
      do rs1 = $random(seed) & 7; while (mul_hazard(rs1));
      do rs2 = $random(seed) & 7; while (mul_hazard(rs2));
      add_slot(((rnd >> 6) & 15) != 0, calc_pkg::calc_op_e'(rnd[2:0]), (rnd >> 3) & 7,
               rs1, rs2, ((rnd >> 12) & 15) == 0);
    end
  endtask

  // Fills rs data and expected writebacks
  task automatic build_expected();
    calc_pkg::calc_data_t     rf_now [32];
    calc_pkg::calc_data_t     rf_old [32];
    calc_pkg::calc_dispatch_s pkt;
    calc_pkg::calc_wb_s       wb;
    calc_pkg::calc_data_t     a;
    calc_pkg::calc_data_t     b;
    bit                       poison;
    int                       n;
    n = prog_q.size();
    for (int r = 0; r < 32; r++)
    begin
      rf_now[r] = 32'h9e3779b9 * (r + 1);
      rf_old[r] = rf_now[r];
    end
    for (int k = 0; k < n; k++)
    begin
      pkt = prog_q[k];
      // Producer just left the forwarding window
      if (k > `CALC_COMP_DEPTH && slot_wb[k-`CALC_COMP_DEPTH-1].w_v)
        rf_old[slot_wb[k-`CALC_COMP_DEPTH-1].rd_addr] = slot_wb[k-`CALC_COMP_DEPTH-1].rd_data;
      poison = (k + 1 < n && flush_q[k+1]) || (k + 2 < n && flush_q[k+2]);
      a = (pkt.rs1_addr == 0) ? '0 : rf_now[pkt.rs1_addr];
      b = (pkt.rs2_addr == 0) ? '0 : rf_now[pkt.rs2_addr];
      // Stale data wherever the DUT has to bypass
      if (pkt.rs1_addr == 0 || in_flight(k, pkt.rs1_addr))
        pkt.rs1_data = $random(seed);
      else
        pkt.rs1_data = rf_old[pkt.rs1_addr];
      if (pkt.rs2_addr == 0 || in_flight(k, pkt.rs2_addr))
        pkt.rs2_data = $random(seed);
      else
        pkt.rs2_data = rf_old[pkt.rs2_addr];
      wb         = '0;
      wb.w_v     = pkt.v && !poison && pkt.rd_addr != 0;
      wb.poison  = poison;
      wb.rd_addr = pkt.rd_addr;
      wb.rd_data = alu_model(pkt.op, a, b);
      if (wb.w_v)
      begin
        rf_now[pkt.rd_addr] = wb.rd_data;
        wb_expected++;
      end
      prog_q[k] = pkt;
      slot_wb.push_back(wb);
    end
  endtask

  // Expected writeback for the current cycle
  always @(negedge clk)
  begin
    exp_wb = '0;
    if (due_q.size() > 0 && due_q[0] == cyc)
    begin
      exp_wb = wb_q.pop_front();
      void'(due_q.pop_front());
    end
    if (wb_pkt.w_v)
      wb_seen++;
  end

  wb_valid_chk: assert property (@(posedge clk) disable iff (!rst_n) wb_pkt.w_v == exp_wb.w_v)
    else report_mismatch("wb_pkt_o.w_v", calc_pkg::calc_data_t'($sampled(exp_wb.w_v)),
                         calc_pkg::calc_data_t'($sampled(wb_pkt.w_v)));

  wb_poison_chk: assert property (@(posedge clk) disable iff (!rst_n)
      wb_pkt.poison == exp_wb.poison)
    else report_mismatch("wb_pkt_o.poison", calc_pkg::calc_data_t'($sampled(exp_wb.poison)),
                         calc_pkg::calc_data_t'($sampled(wb_pkt.poison)));

  wb_rd_chk: assert property (@(posedge clk) disable iff (!rst_n)
      exp_wb.w_v |-> wb_pkt.rd_addr == exp_wb.rd_addr)
    else report_mismatch("wb_pkt_o.rd_addr", calc_pkg::calc_data_t'($sampled(exp_wb.rd_addr)),
                         calc_pkg::calc_data_t'($sampled(wb_pkt.rd_addr)));

  wb_data_chk: assert property (@(posedge clk) disable iff (!rst_n)
      exp_wb.w_v |-> wb_pkt.rd_data == exp_wb.rd_data)
    else report_mismatch("wb_pkt_o.rd_data", $sampled(exp_wb.rd_data),
                         $sampled(wb_pkt.rd_data));

  initial
  begin
    wait (prog_built);
    repeat (RESET_CYCLES + prog_q.size() + 100) @(posedge clk);
    stop_with_failure("Timeout: the writebacks did not drain within the cycle budget");
  end

  initial
  begin
    rst_n        = 1'b0;
    flush        = 1'b0;
    dispatch_pkt = '0;
    build_program();
    build_expected();
    prog_built = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (int k = 0; k < prog_q.size(); k++)
    begin
      @(negedge clk);
      dispatch_pkt = prog_q[k];
      flush        = flush_q[k];
      due_q.push_back(cyc + 1 + `CALC_COMP_DEPTH);
      wb_q.push_back(slot_wb[k]);
    end
    @(negedge clk);
    dispatch_pkt = '0;
    flush        = 1'b0;
    while (due_q.size() != 0)
      @(negedge clk);
    repeat (`CALC_COMP_DEPTH + 2) @(negedge clk);
    if (wb_seen == wb_expected)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
      stop_with_failure("Number of writebacks differs from the reference model");
  end

endmodule

//--- build.f
+incdir+hdl
hdl/calc_pkg.sv
hdl/calc_issue.sv
hdl/calc_pipe_int.sv
hdl/calc_pipe_mul.sv
hdl/calc_completion.sv
hdl/calc_top.sv
bench/calc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the calculator testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f build.f \
  --top-module calc_tb \
  -Mdir obj_dir

# Pass only if the testbench printed its pass line
if ./obj_dir/Vcalc_tb | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null
then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
